//--- Makefile
# Verilator build and run for the RGMII link test

VERILATOR ?= verilator
TOP ?= rgmii_hw_test_tb
FILELIST ?= rgmii_hw_test.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard include/*.svh source/*.sv sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits non-zero on $fatal
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- include/rgmii_hw_test_config.svh
/*
 * RGMII link test configuration
 * Frame framing constants, counter width and register count
 */
`ifndef RGMII_HW_TEST_CONFIG_SVH
`define RGMII_HW_TEST_CONFIG_SVH

// Ethernet framing
`define PREAMBLE_LEN 7
`define PREAMBLE_BYTE 8'h55
`define SFD_BYTE 8'hD5

// Width of the good and bad frame counters
`define FRAME_COUNT_WIDTH 16

// Number of configuration registers
`define NUM_REGS 4

`endif

//--- rgmii_hw_test.f
+incdir+include
source/eth_frame_pkg.sv
source/regmap_pkg.sv
source/gmii_to_rgmii.sv
source/spi_config_regs.sv
source/frame_generator.sv
source/frame_checker.sv
source/hw_test.sv
source/rgmii_hw_test.sv
sim/tb_clock.sv
sim/rgmii_hw_test_tb.sv

//--- sim/rgmii_hw_test_tb.sv
/*
 * Testbench for the RGMII link test
 * Loops RGMII transmit to receive, programs the registers over SPI, checks frames and LEDs
 */
`timescale 1ns/1ps
`include "rgmii_hw_test_config.svh"

module rgmii_hw_test_tb;
	import eth_frame_pkg::*;
	import regmap_pkg::*;

	localparam reg_data_t phy_only = reg_data_t'(1 << CTRL_PHY_RUN);
	localparam reg_data_t gen_and_phy = phy_only | reg_data_t'(1 << CTRL_GEN_EN);

	logic tx_clk, rst_n, sclk, csb, mosi;
	nibble_t rgmii_txd, rgmii_rxd, fault_mask, lo_nib;
	logic rgmii_tx_ctrl, rgmii_rx_ctrl, rgmii_tx_clk, rgmii_rx_clk, phy_rstn;
	logic ctl_rise;
	logic [3:0] led;
	logic [15:0] lfsr;
	// Generator model and decoder bookkeeping
	int exp_len, exp_gap, exp_start;
	logic in_frame;
	int byte_pos, idle_run, frames_started, frames_done, faults_done;

	tb_clock #(.period_ns(100.0)) clock_i (.clk(tx_clk));

	rgmii_hw_test rgmii_hw_test_i (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.RGMII_RXD(rgmii_rxd), .RGMII_RX_CTRL(rgmii_rx_ctrl), .RGMII_RX_CLK(rgmii_rx_clk),
		.SCLK(sclk), .CSB(csb), .MOSI(mosi),
		.RGMII_TXD(rgmii_txd), .RGMII_TX_CTRL(rgmii_tx_ctrl), .RGMII_TX_CLK(rgmii_tx_clk),
		.PHY_RSTN(phy_rstn), .LED(led)
	);

	// Loopback with the receive clock skewed a quarter period into each nibble
	// Fault mask acts only on the low nibble in the high clock phase
	assign rgmii_rxd = rgmii_txd ^ (rgmii_tx_clk ? fault_mask : 4'b0000);
	assign rgmii_rx_ctrl = rgmii_tx_ctrl;
	assign #25 rgmii_rx_clk = rgmii_tx_clk;

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic value_error(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic run_error(input string msg);
		$display("Failure at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per random bit
	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// Rebuild one byte per DDR period and compare it with the model
	task automatic decode_byte(input byte_t data, input logic en, input logic ctl_fall);
		byte_t want;
		assert (ctl_fall == en) else value_error("RGMII_TX_CTRL changed within a byte");
		if (en) begin
			if (!in_frame) begin
				assert (idle_run >= exp_gap)
					else value_error($sformatf("gap of %0d bytes, at least %0d expected",
						idle_run, exp_gap));
				in_frame = 1'b1;
				byte_pos = 0;
				frames_started++;
			end
			if (byte_pos < `PREAMBLE_LEN)
				want = `PREAMBLE_BYTE;
			else if (byte_pos == `PREAMBLE_LEN)
				want = `SFD_BYTE;
			else
				want = byte_t'(exp_start + byte_pos - `PREAMBLE_LEN - 1);
			assert (byte_pos < `PREAMBLE_LEN + 1 + exp_len)
				else value_error("frame longer than the configured payload");
			assert (data == want)
				else value_error($sformatf("frame byte %0d is %02h, expected %02h",
					byte_pos, data, want));
			byte_pos++;
		end else begin
			if (in_frame) begin
				assert (byte_pos == `PREAMBLE_LEN + 1 + exp_len)
					else value_error($sformatf("frame of %0d bytes, expected %0d",
						byte_pos, `PREAMBLE_LEN + 1 + exp_len));
				in_frame = 1'b0;
				frames_done++;
				idle_run = 0;
			end
			idle_run++;
		end
	endtask

	always @(posedge rgmii_rx_clk) begin
		lo_nib <= rgmii_txd;
		ctl_rise <= rgmii_tx_ctrl;
	end

	always @(negedge rgmii_rx_clk) begin
		if (rst_n)
			decode_byte({rgmii_txd, lo_nib}, ctl_rise, rgmii_tx_ctrl);
	end

	task automatic check_reset_outputs();
		assert (phy_rstn === 1'b0) else value_error("PHY_RSTN not low in reset");
		assert (rgmii_tx_ctrl === 1'b0) else value_error("RGMII_TX_CTRL not low in reset");
		assert (led === 4'b0000) else value_error("LED not cleared in reset");
	endtask

	// Sends MSB first with SCLK at a quarter of tx_clk
	task automatic spi_transfer(input logic [15:0] word, input int nbits);
		csb = 1'b0;
		repeat (2) @(negedge tx_clk);
		for (int i = 0; i < nbits; i++) begin
			mosi = word[15 - i];
			sclk = 1'b0;
			repeat (2) @(negedge tx_clk);
			sclk = 1'b1;
			repeat (2) @(negedge tx_clk);
		end
		sclk = 1'b0;
		repeat (2) @(negedge tx_clk);
		csb = 1'b1;
	endtask

	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		spi_transfer({addr, data}, 16);
		repeat (6) @(negedge tx_clk);
	endtask

	task automatic wait_phy_run();
		int n;
		n = 0;
		while (!(phy_rstn && led[0]) && n < 6) begin
			@(negedge tx_clk);
			n++;
		end
		assert (phy_rstn && led[0])
			else value_error("PHY_RSTN or LED[0] not high within 6 cycles of CSB rising");
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames_done < target && n < 20000) begin
			@(negedge tx_clk);
			n++;
		end
		if (frames_done < target)
			run_error("timed out waiting for frames on the RGMII transmit pins");
	endtask

	// Longer than any gap, so the generator has stopped
	task automatic wait_quiet();
		int n;
		n = 0;
		while ((in_frame || idle_run < 64) && n < 2000) begin
			@(negedge tx_clk);
			n++;
		end
		if (in_frame || idle_run < 64)
			run_error("generator did not go quiet after being disabled");
	endtask

	// Flips bit 0 of the low nibble of one payload byte on the receive side
	task automatic inject_fault(input int payload_idx);
		int n;
		n = 0;
		do begin
			@(negedge tx_clk);
			n++;
		end while (rgmii_tx_ctrl && n < 1000);
		while (!rgmii_tx_ctrl && n < 1000) begin
			@(negedge tx_clk);
			n++;
		end
		if (n >= 1000)
			run_error("no frame started for the fault injection");
		// Raised at the falling edge before the byte and gated to its high clock phase
		repeat (`PREAMBLE_LEN + payload_idx) @(negedge tx_clk);
		fault_mask = 4'b0001;
		@(negedge tx_clk);
		fault_mask = 4'b0000;
		faults_done++;
	endtask

	task automatic configure(input int len, input int gap, input int start);
		write_reg(ADDR_PAYLOAD_LEN, reg_data_t'(len));
		write_reg(ADDR_GAP_LEN, reg_data_t'(gap));
		write_reg(ADDR_START_BYTE, reg_data_t'(start));
		// Length 0 reads as 1 and gaps below 12 read as 12
		exp_len = (len == 0) ? 1 : len;
		exp_gap = (gap < 12) ? 12 : gap;
		exp_start = start;
	endtask

	task automatic check_status(input logic bad_expected);
		int good_exp;
		good_exp = frames_done - faults_done;
		assert (led[3:2] == 2'(good_exp % 4))
			else value_error($sformatf("LED[3:2] is %0d after %0d good frames",
				led[3:2], good_exp));
		assert (led[1] == bad_expected)
			else value_error($sformatf("LED[1] is %0b, expected %0b", led[1], bad_expected));
		assert (led[0] && phy_rstn) else value_error("PHY_RSTN or LED[0] dropped");
	endtask

	task automatic run_good_round(input int nframes, input logic bad_expected);
		int v, gap, start;
		take_bits(6, v);
		take_bits(5, gap);
		take_bits(8, start);
		configure(v % 40 + 1, gap, start);
		write_reg(ADDR_CTRL, gen_and_phy);
		wait_frames(frames_done + nframes);
		write_reg(ADDR_CTRL, phy_only);
		wait_quiet();
		check_status(bad_expected);
	endtask

	initial begin
		int v, len, gap, start, k, stop_frames;
		lfsr = 16'd48;
		rst_n = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		fault_mask = 4'b0000;
		exp_len = 1;
		exp_gap = 12;
		exp_start = 0;
		in_frame = 1'b0;
		byte_pos = 0;
		idle_run = 1000;
		frames_started = 0;
		frames_done = 0;
		faults_done = 0;

		repeat (8) begin
			@(negedge tx_clk);
			check_reset_outputs();
		end
		rst_n = 1'b1;
		@(negedge tx_clk);
		check_reset_outputs();

		// PHY reset release and then a short transfer that would clear it
		spi_transfer({ADDR_CTRL, phy_only}, 16);
		wait_phy_run();
		repeat (6) @(negedge tx_clk);
		spi_transfer(16'h0000, 15);
		repeat (10) @(negedge tx_clk);
		assert (phy_rstn && led == 4'b0001 && frames_started == 0)
			else value_error("15-bit SPI transfer changed the registers");

		repeat (3) run_good_round(5, 1'b0);

		// One corrupted payload byte after the first
		take_bits(6, v);
		len = v % 39 + 2;
		take_bits(5, gap);
		take_bits(8, start);
		take_bits(6, v);
		k = v % (len - 1) + 1;
		configure(len, gap, start);
		write_reg(ADDR_CTRL, gen_and_phy);
		inject_fault(k);
		wait_frames(frames_done + 2);
		write_reg(ADDR_CTRL, phy_only);
		wait_quiet();
		check_status(1'b1);
		run_good_round(3, 1'b1);

		// Long frame disabled while it is on the wire
		take_bits(5, gap);
		take_bits(8, start);
		configure(200, gap, start);
		write_reg(ADDR_CTRL, gen_and_phy);
		v = 0;
		while (!(in_frame && byte_pos < `PREAMBLE_LEN) && v < 500) begin
			@(negedge tx_clk);
			v++;
		end
		if (!(in_frame && byte_pos < `PREAMBLE_LEN))
			run_error("no frame start seen before the stop request");
		spi_transfer({ADDR_CTRL, phy_only}, 16);
		assert (in_frame && byte_pos < `PREAMBLE_LEN + 1 + exp_len)
			else run_error("stop request did not fall inside a frame");
		stop_frames = frames_started;
		wait_quiet();
		repeat (100) @(negedge tx_clk);
		assert (frames_started == stop_frames)
			else value_error("frame started after the generator was disabled");
		check_status(1'b1);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- sim/tb_clock.sv
/*
 * Testbench clock source, free running from time zero
 */
`timescale 1ns/1ps

module tb_clock #(
	parameter real period_ns = 100.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2.0) clk = ~clk;
	end

endmodule

//--- source/eth_frame_pkg.sv
/*
 * Ethernet frame types shared by the generator, checker and DDR converter
 */
`include "rgmii_hw_test_config.svh"

package eth_frame_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [3:0] nibble_t;
	typedef logic [`FRAME_COUNT_WIDTH-1:0] frame_count_t;

	typedef enum logic [2:0] {
		GEN_IDLE,
		GEN_PREAMBLE,
		GEN_SFD,
		GEN_PAYLOAD,
		GEN_GAP
	} gen_state_t;

	typedef enum logic [1:0] {CHK_IDLE, CHK_PREAMBLE, CHK_PAYLOAD, CHK_DROP} chk_state_t;

endpackage

//--- source/frame_checker.sv
/*
 * Frame checker for GMII receive
 * Finds the SFD, checks payload continuity, counts good and bad frames
 */
`timescale 1ns/1ps
`include "rgmii_hw_test_config.svh"

module frame_checker (
	input  logic                        clk,
	input  logic                        rst_n,
	input  eth_frame_pkg::byte_t        rxd,
	input  logic                        rx_dv,
	input  logic                        rx_er,
	output eth_frame_pkg::frame_count_t good_count,
	output eth_frame_pkg::frame_count_t bad_count
);
	import eth_frame_pkg::*;

	chk_state_t state;
	byte_t last_q;
	logic err_q;
	logic seen_q;

	// Last payload byte, only meaningful once seen_q is set
	always_ff @(posedge clk) begin
		if (state == CHK_PAYLOAD && rx_dv)
			last_q <= rxd;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CHK_IDLE;
			err_q <= 1'b0;
			seen_q <= 1'b0;
			good_count <= '0;
			bad_count <= '0;
		end else begin
			case (state)
				CHK_IDLE: if (rx_dv) begin
					err_q <= rx_er;
					seen_q <= 1'b0;
					state <= (rxd == `PREAMBLE_BYTE) ? CHK_PREAMBLE : CHK_DROP;
				end
				CHK_PREAMBLE: if (!rx_dv) begin
					bad_count <= bad_count + 1'b1;
					state <= CHK_IDLE;
				end else begin
					err_q <= err_q | rx_er;
					if (rxd == `SFD_BYTE)
						state <= CHK_PAYLOAD;
					else if (rxd != `PREAMBLE_BYTE)
						state <= CHK_DROP;
				end
				CHK_PAYLOAD: if (!rx_dv) begin
					// End of frame, judge it
					if (seen_q && !err_q)
						good_count <= good_count + 1'b1;
					else
						bad_count <= bad_count + 1'b1;
					state <= CHK_IDLE;
				end else begin
					seen_q <= 1'b1;
					if (rx_er || (seen_q && rxd != last_q + 8'd1))
						err_q <= 1'b1;
				end
				CHK_DROP: if (!rx_dv) begin
					bad_count <= bad_count + 1'b1;
					state <= CHK_IDLE;
				end
				default: state <= CHK_IDLE;
			endcase
		end
	end

	a_good_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		good_count == $past(good_count) || good_count == $past(good_count) + 1'b1);
	a_bad_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		bad_count == $past(bad_count) || bad_count == $past(bad_count) + 1'b1);

endmodule

//--- source/frame_generator.sv
/*
 * Frame generator for GMII transmit
 * Preamble, SFD, incrementing payload, then inter-frame gap
 */
`timescale 1ns/1ps
`include "rgmii_hw_test_config.svh"

module frame_generator (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  gen_en,
	input  regmap_pkg::reg_data_t payload_len,
	input  regmap_pkg::reg_data_t gap_len,
	input  regmap_pkg::reg_data_t start_byte,
	output eth_frame_pkg::byte_t  txd,
	output logic                  tx_en,
	output logic                  tx_er
);
	import eth_frame_pkg::*;
	import regmap_pkg::*;

	gen_state_t state;
	byte_t cnt;
	byte_t data_q;
	reg_data_t len_q, gap_q;

	// Settings are latched only when a frame starts
	always_ff @(posedge clk) begin
		if (state == GEN_IDLE && gen_en) begin
			len_q <= payload_len;
			gap_q <= gap_len;
		end
		if (state == GEN_IDLE)
			data_q <= start_byte;
		else if (state == GEN_SFD || state == GEN_PAYLOAD)
			data_q <= data_q + 8'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= GEN_IDLE;
			cnt <= '0;
			txd <= '0;
			tx_en <= 1'b0;
		end else begin
			case (state)
				GEN_IDLE: if (gen_en) begin
					state <= GEN_PREAMBLE;
					cnt <= 8'd1;
					txd <= `PREAMBLE_BYTE;
					tx_en <= 1'b1;
				end
				GEN_PREAMBLE: if (cnt == 8'(`PREAMBLE_LEN)) begin
					state <= GEN_SFD;
					txd <= `SFD_BYTE;
				end else begin
					cnt <= cnt + 8'd1;
				end
				GEN_SFD: begin
					state <= GEN_PAYLOAD;
					cnt <= 8'd1;
					txd <= data_q;
				end
				GEN_PAYLOAD: if (cnt == len_q) begin
					state <= GEN_GAP;
					cnt <= 8'd1;
					txd <= '0;
					tx_en <= 1'b0;
				end else begin
					cnt <= cnt + 8'd1;
					txd <= data_q;
				end
				GEN_GAP: if (cnt == gap_q)
					state <= GEN_IDLE;
				else
					cnt <= cnt + 8'd1;
				default: state <= GEN_IDLE;
			endcase
		end
	end

	assign tx_er = 1'b0;

	a_payload_tx_en: assert property (@(posedge clk) disable iff (!rst_n)
		state == GEN_PAYLOAD |-> tx_en);

endmodule

//--- source/gmii_to_rgmii.sv
/*
 * GMII to RGMII converter
 * Behavioural DDR registers for transmit and receive
 */
`timescale 1ns/1ps

module gmii_to_rgmii (
	input  logic                  gmii_tx_clk,
	input  logic                  rst_n,
	input  eth_frame_pkg::byte_t  gmii_txd,
	input  logic                  gmii_tx_en,
	input  logic                  gmii_tx_er,
	input  eth_frame_pkg::nibble_t rgmii_rxd,
	input  logic                  rgmii_rx_ctl,
	input  logic                  rgmii_rx_clk,
	output eth_frame_pkg::nibble_t rgmii_txd,
	output logic                  rgmii_tx_ctl,
	output logic                  rgmii_tx_clk,
	output eth_frame_pkg::byte_t  gmii_rxd,
	output logic                  gmii_rx_clk,
	output logic                  gmii_rx_dv,
	output logic                  gmii_rx_er
);
	import eth_frame_pkg::*;

	byte_t txd_q;
	logic tx_en_q, tx_er_q;
	nibble_t rx_lo_q, rx_hi_q;
	logic rx_ctl_rise_q, rx_ctl_fall_q;

	// Transmit byte held for one full tx_clk period
	always_ff @(posedge gmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_en_q <= 1'b0;
			tx_er_q <= 1'b0;
		end else begin
			tx_en_q <= gmii_tx_en;
			tx_er_q <= gmii_tx_er;
		end
	end

	always_ff @(posedge gmii_tx_clk) begin
		txd_q <= gmii_txd;
	end

	// Low nibble while the clock is high, high nibble while low
	assign rgmii_txd = gmii_tx_clk ? txd_q[3:0] : txd_q[7:4];
	assign rgmii_tx_ctl = gmii_tx_clk ? tx_en_q : (tx_en_q ^ tx_er_q);
	assign rgmii_tx_clk = gmii_tx_clk;

	// Receive side, capture on both edges
	assign gmii_rx_clk = rgmii_rx_clk;

	always_ff @(posedge rgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_ctl_rise_q <= 1'b0;
			gmii_rx_dv <= 1'b0;
			gmii_rx_er <= 1'b0;
		end else begin
			rx_ctl_rise_q <= rgmii_rx_ctl;
			gmii_rx_dv <= rx_ctl_rise_q;
			gmii_rx_er <= rx_ctl_rise_q ^ rx_ctl_fall_q;
		end
	end

	always_ff @(negedge rgmii_rx_clk or negedge rst_n) begin
		if (!rst_n)
			rx_ctl_fall_q <= 1'b0;
		else
			rx_ctl_fall_q <= rgmii_rx_ctl;
	end

	always_ff @(posedge rgmii_rx_clk) begin
		rx_lo_q <= rgmii_rxd;
		gmii_rxd <= {rx_hi_q, rx_lo_q};
	end

	always_ff @(negedge rgmii_rx_clk) begin
		rx_hi_q <= rgmii_rxd;
	end

endmodule

//--- source/hw_test.sv
/*
 * Link test core
 * Registers, generator, checker, PHY reset and status LEDs
 */
`timescale 1ns/1ps

module hw_test (
	input  logic                 vgmii_tx_clk,
	input  logic                 rst_n,
	input  eth_frame_pkg::byte_t vgmii_rxd,
	input  logic                 vgmii_rx_clk,
	input  logic                 vgmii_rx_dv,
	input  logic                 vgmii_rx_er,
	input  logic                 SCLK,
	input  logic                 CSB,
	input  logic                 MOSI,
	output eth_frame_pkg::byte_t vgmii_txd,
	output logic                 vgmii_tx_en,
	output logic                 vgmii_tx_er,
	output logic                 phy_rstn,
	output logic [3:0]           LED
);
	import eth_frame_pkg::*;
	import regmap_pkg::*;

	logic gen_en, phy_run;
	reg_data_t payload_len, gap_len, start_byte;
	frame_count_t good_count, bad_count;
	logic bad_seen;

	spi_config_regs regs_i (
		.clk(vgmii_tx_clk), .rst_n(rst_n),
		.sclk(SCLK), .csb(CSB), .mosi(MOSI),
		.gen_en(gen_en), .phy_run(phy_run),
		.payload_len(payload_len), .gap_len(gap_len), .start_byte(start_byte)
	);

	frame_generator gen_i (
		.clk(vgmii_tx_clk), .rst_n(rst_n), .gen_en(gen_en),
		.payload_len(payload_len), .gap_len(gap_len), .start_byte(start_byte),
		.txd(vgmii_txd), .tx_en(vgmii_tx_en), .tx_er(vgmii_tx_er)
	);

	frame_checker chk_i (
		.clk(vgmii_rx_clk), .rst_n(rst_n),
		.rxd(vgmii_rxd), .rx_dv(vgmii_rx_dv), .rx_er(vgmii_rx_er),
		.good_count(good_count), .bad_count(bad_count)
	);

	// Sticky once any bad frame was counted
	always_ff @(posedge vgmii_rx_clk or negedge rst_n) begin
		if (!rst_n)
			bad_seen <= 1'b0;
		else if (bad_count != '0)
			bad_seen <= 1'b1;
	end

	assign phy_rstn = phy_run;
	assign LED = {good_count[1:0], bad_seen, phy_run};

endmodule

//--- source/regmap_pkg.sv
/*
 * Register map of the SPI configuration block
 */
package regmap_pkg;

	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Register addresses
	localparam reg_addr_t ADDR_CTRL        = 8'd0;
	localparam reg_addr_t ADDR_PAYLOAD_LEN = 8'd1;
	localparam reg_addr_t ADDR_GAP_LEN     = 8'd2;
	localparam reg_addr_t ADDR_START_BYTE  = 8'd3;

	// Control register bits
	localparam int CTRL_GEN_EN  = 0;
	localparam int CTRL_PHY_RUN = 1;

	// Smallest usable lengths
	localparam reg_data_t PAYLOAD_MIN = 8'd1;
	localparam reg_data_t GAP_MIN     = 8'd12;

endpackage

//--- source/rgmii_hw_test.sv
/*
 * RGMII hardware test top level
 */
`timescale 1ns/1ps

module rgmii_hw_test (
	input  logic                   tx_clk,
	input  logic                   rst_n,
	input  eth_frame_pkg::nibble_t RGMII_RXD,
	input  logic                   RGMII_RX_CTRL,
	input  logic                   RGMII_RX_CLK,
	input  logic                   SCLK,
	input  logic                   CSB,
	input  logic                   MOSI,
	output eth_frame_pkg::nibble_t RGMII_TXD,
	output logic                   RGMII_TX_CTRL,
	output logic                   RGMII_TX_CLK,
	output logic                   PHY_RSTN,
	output logic [3:0]             LED
);
	import eth_frame_pkg::*;

	byte_t vgmii_txd, vgmii_rxd;
	logic vgmii_tx_en, vgmii_tx_er;
	logic vgmii_rx_clk, vgmii_rx_dv, vgmii_rx_er;

	// DDR conversion at the PHY pins
	gmii_to_rgmii gmii_to_rgmii_i (
		.gmii_tx_clk(tx_clk), .rst_n(rst_n),
		.gmii_txd(vgmii_txd), .gmii_tx_en(vgmii_tx_en), .gmii_tx_er(vgmii_tx_er),
		.rgmii_rxd(RGMII_RXD), .rgmii_rx_ctl(RGMII_RX_CTRL), .rgmii_rx_clk(RGMII_RX_CLK),
		.rgmii_txd(RGMII_TXD), .rgmii_tx_ctl(RGMII_TX_CTRL), .rgmii_tx_clk(RGMII_TX_CLK),
		.gmii_rxd(vgmii_rxd), .gmii_rx_clk(vgmii_rx_clk),
		.gmii_rx_dv(vgmii_rx_dv), .gmii_rx_er(vgmii_rx_er)
	);

	hw_test vgmii (
		.vgmii_tx_clk(tx_clk), .rst_n(rst_n),
		.vgmii_rxd(vgmii_rxd), .vgmii_rx_clk(vgmii_rx_clk),
		.vgmii_rx_dv(vgmii_rx_dv), .vgmii_rx_er(vgmii_rx_er),
		.SCLK(SCLK), .CSB(CSB), .MOSI(MOSI),
		.vgmii_txd(vgmii_txd), .vgmii_tx_en(vgmii_tx_en), .vgmii_tx_er(vgmii_tx_er),
		.phy_rstn(PHY_RSTN), .LED(LED)
	);

endmodule

//--- source/spi_config_regs.sv
/*
 * SPI configuration registers
 * Write-only 16-bit slave, address byte then data byte
 */
`timescale 1ns/1ps
`include "rgmii_hw_test_config.svh"

module spi_config_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sclk,
	input  logic                  csb,
	input  logic                  mosi,
	output logic                  gen_en,
	output logic                  phy_run,
	output regmap_pkg::reg_data_t payload_len,
	output regmap_pkg::reg_data_t gap_len,
	output regmap_pkg::reg_data_t start_byte
);
	import regmap_pkg::*;

	logic sclk_meta, sclk_s, sclk_d;
	logic csb_meta, csb_s, csb_d;
	logic mosi_meta, mosi_s;
	logic sclk_rise, csb_rise;
	logic [15:0] shift_q;
	logic [4:0] bit_cnt;
	logic wr_pend;
	reg_addr_t wr_addr;
	reg_data_t ctrl_q, payload_q, gap_q, start_q;

	// Pin synchronizers, CSB idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{sclk_meta, sclk_s, sclk_d} <= 3'b000;
			{csb_meta, csb_s, csb_d} <= 3'b111;
			{mosi_meta, mosi_s} <= 2'b00;
		end else begin
			{sclk_meta, sclk_s, sclk_d} <= {sclk, sclk_meta, sclk_s};
			{csb_meta, csb_s, csb_d} <= {csb, csb_meta, csb_s};
			{mosi_meta, mosi_s} <= {mosi, mosi_meta};
		end
	end

	assign sclk_rise = sclk_s & ~sclk_d;
	assign csb_rise = csb_s & ~csb_d;

	always_ff @(posedge clk) begin
		if (!csb_s && sclk_rise)
			shift_q <= {shift_q[14:0], mosi_s};
	end

	// Bit count saturates so long transfers never look like 16 bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= 5'd0;
			wr_pend <= 1'b0;
		end else begin
			if (csb_s)
				bit_cnt <= 5'd0;
			else if (sclk_rise && bit_cnt != 5'd31)
				bit_cnt <= bit_cnt + 5'd1;
			wr_pend <= csb_rise && (bit_cnt == 5'd16);
		end
	end

	assign wr_addr = shift_q[15:8];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;
			payload_q <= '0;
			gap_q <= '0;
			start_q <= '0;
		end else if (wr_pend && wr_addr < reg_addr_t'(`NUM_REGS)) begin
			case (wr_addr)
				ADDR_CTRL:        ctrl_q <= shift_q[7:0];
				ADDR_PAYLOAD_LEN: payload_q <= shift_q[7:0];
				ADDR_GAP_LEN:     gap_q <= shift_q[7:0];
				ADDR_START_BYTE:  start_q <= shift_q[7:0];
				default: ;
			endcase
		end
	end

	assign gen_en = ctrl_q[CTRL_GEN_EN];
	assign phy_run = ctrl_q[CTRL_PHY_RUN];
	// Length floors
	assign payload_len = (payload_q == '0) ? PAYLOAD_MIN : payload_q;
	assign gap_len = (gap_q < GAP_MIN) ? GAP_MIN : gap_q;
	assign start_byte = start_q;

endmodule
